/* pmem_pkg.sv */
package pmem_pkg;

  localparam int NUM_PORTS = 4;
  localparam int DATA_W = 64;
  localparam int MAX_WORDS = 8;
  localparam int SLOTS = 16;
  localparam int JOB_DEPTH = 4;
  // Drop frees that lost against an egress free
  localparam int FREE_DEPTH = 2;

  typedef logic [1:0] port_t;
  typedef logic [3:0] slot_t;
  typedef logic [2:0] word_idx_t;

  // Holds 1 to MAX_WORDS
  typedef logic [3:0] len_t;

  typedef struct packed {
    port_t port;
    slot_t slot;
  } channel_t;

  // Match result from the external matcher
  typedef struct packed {
    logic     rsvd;
    logic     drop;
    port_t    dest;
    channel_t channel;
  } tag_t;

  typedef struct packed {
    channel_t channel;
  } job_t;

endpackage

/* pmem_fifo.sv */
`timescale 1ns/1ps

module pmem_fifo #(
  parameter type payload_t = logic,
  parameter int DEPTH = 2
) (
  input  logic     clock,
  input  logic     arst_n,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     empty,
  output logic     full
);

  payload_t mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic do_push;
  logic do_pop;

  function automatic logic [$clog2(DEPTH)-1:0] next_ptr(input logic [$clog2(DEPTH)-1:0] ptr);
    if (ptr == ($clog2(DEPTH))'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full = (count == ($clog2(DEPTH+1))'(DEPTH));
  assign do_pop = pop && !empty;
  // A full queue still takes a push when the head leaves in the same cycle
  assign do_push = push && (!full || do_pop);
  assign dout = mem[rd_ptr];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + ($clog2(DEPTH+1))'(do_push) - ($clog2(DEPTH+1))'(do_pop);
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

/* pmem_ingress.sv */
`timescale 1ns/1ps

module pmem_ingress #(
  parameter pmem_pkg::port_t PORT = '0
) (
  input  logic                        clock,
  input  logic                        arst_n,

  input  logic [pmem_pkg::DATA_W-1:0] packetin_data,
  input  logic                        packetin_valid,
  input  logic                        packetin_sop,
  input  logic                        packetin_eop,
  output logic                        packetin_ready,

  output logic [pmem_pkg::DATA_W-1:0] packetout_data,
  output logic                        packetout_valid,
  output logic                        packetout_sop,
  output logic                        packetout_eop,
  input  logic                        packetout_ready,
  output pmem_pkg::channel_t          packetout_channel,

  input  logic                        free_valid,
  input  pmem_pkg::channel_t          free_channel,

  input  pmem_pkg::channel_t          rd_channel,
  input  pmem_pkg::word_idx_t         rd_word,
  output logic [pmem_pkg::DATA_W-1:0] rd_data,
  output pmem_pkg::len_t              rd_len
);

  import pmem_pkg::*;

  // Packet words addressed by slot then word index
  logic [DATA_W-1:0] bank [SLOTS*MAX_WORDS];
  len_t len_tab [SLOTS];

  logic [SLOTS-1:0] free_map;
  logic in_pkt;
  slot_t cur_slot;
  word_idx_t word_cnt;

  slot_t alloc_slot;
  logic have_free;
  logic can_take;
  slot_t wr_slot;
  word_idx_t wr_word;
  logic accept;

  // Lowest free slot wins
  always_comb begin : alloc_search
    alloc_slot = '0;
    for (int i = SLOTS - 1; i >= 0; i--) begin
      if (free_map[i]) begin
        alloc_slot = slot_t'(i);
      end
    end
  end

  assign have_free = |free_map;

  // A new packet needs a slot, a packet in progress already has one
  assign can_take = in_pkt || have_free;

  assign wr_slot = in_pkt ? cur_slot : alloc_slot;
  assign wr_word = in_pkt ? word_cnt : '0;

  assign packetout_valid = packetin_valid && can_take;
  assign packetin_ready = packetout_ready && can_take;
  assign accept = packetin_valid && packetin_ready;

  assign packetout_data = packetin_data;
  assign packetout_sop = packetin_sop;
  assign packetout_eop = packetin_eop;
  assign packetout_channel = '{port: PORT, slot: wr_slot};

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      free_map <= '1;
      in_pkt <= 1'b0;
      cur_slot <= '0;
      word_cnt <= '0;
    end else begin
      if (accept) begin
        if (!in_pkt) begin
          free_map[alloc_slot] <= 1'b0;
        end
        if (packetin_eop) begin
          in_pkt <= 1'b0;
          word_cnt <= '0;
        end else begin
          in_pkt <= 1'b1;
          cur_slot <= wr_slot;
          word_cnt <= word_idx_t'(wr_word + 1'b1);
        end
      end
      // Frees only ever target occupied slots
      if (free_valid && free_channel.port == PORT) begin
        free_map[free_channel.slot] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      bank[{wr_slot, wr_word}] <= packetin_data;
    end
    if (accept && packetin_eop) begin
      len_tab[wr_slot] <= len_t'(wr_word) + len_t'(1);
    end
  end

  // Registered read when egress addresses this port
  always_ff @(posedge clock) begin
    if (rd_channel.port == PORT) begin
      rd_data <= bank[{rd_channel.slot, rd_word}];
      rd_len <= len_tab[rd_channel.slot];
    end
  end

endmodule

/* pmem_dispatch.sv */
`timescale 1ns/1ps

module pmem_dispatch (
  input  logic                                           clock,
  input  logic                                           arst_n,
  input  pmem_pkg::tag_t                                 tagin_data,
  input  logic                                           tagin_valid,
  output logic                                           tagin_ready,
  output logic [pmem_pkg::NUM_PORTS-1:0]                 job_valid,
  output pmem_pkg::channel_t [pmem_pkg::NUM_PORTS-1:0]   job_channel,
  input  logic [pmem_pkg::NUM_PORTS-1:0]                 job_pop,
  input  logic                                           egr_free,
  input  pmem_pkg::channel_t                             egr_channel,
  output logic                                           free_valid,
  output pmem_pkg::channel_t                             free_channel
);

  import pmem_pkg::*;

  logic [NUM_PORTS-1:0] q_full;
  logic [NUM_PORTS-1:0] q_empty;
  job_t q_head [NUM_PORTS];
  job_t new_job;
  logic tag_hs;

  logic drop_vld;
  channel_t drop_ch;
  logic pend_push;
  logic pend_pop;
  logic pend_empty;
  channel_t pend_ch;

  // Drops never wait, forwards wait for room in their queue
  assign tagin_ready = tagin_data.drop || !q_full[tagin_data.dest];
  assign tag_hs = tagin_valid && tagin_ready;
  assign new_job = '{channel: tagin_data.channel};

  for (genvar d = 0; d < NUM_PORTS; d++) begin : g_jobq
    pmem_fifo #(
      .payload_t (job_t),
      .DEPTH     (JOB_DEPTH)
    ) u_jobq (
      .clock  (clock),
      .arst_n (arst_n),
      .push   (tag_hs && !tagin_data.drop && tagin_data.dest == port_t'(d)),
      .din    (new_job),
      .pop    (job_pop[d]),
      .dout   (q_head[d]),
      .empty  (q_empty[d]),
      .full   (q_full[d])
    );

    assign job_valid[d] = !q_empty[d];
    assign job_channel[d] = q_head[d].channel;
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      drop_vld <= 1'b0;
    end else begin
      drop_vld <= tag_hs && tagin_data.drop;
    end
  end

  always_ff @(posedge clock) begin
    if (tag_hs) begin
      drop_ch <= tagin_data.channel;
    end
  end

  // Egress free first, then held drops, then the fresh drop
  assign pend_pop = !egr_free && !pend_empty;
  assign pend_push = drop_vld && (egr_free || !pend_empty);

  pmem_fifo #(
    .payload_t (channel_t),
    .DEPTH     (FREE_DEPTH)
  ) u_pend (
    .clock  (clock),
    .arst_n (arst_n),
    .push   (pend_push),
    .din    (drop_ch),
    .pop    (pend_pop),
    .dout   (pend_ch),
    .empty  (pend_empty),
    .full   ()
  );

  assign free_valid = egr_free || !pend_empty || drop_vld;
  assign free_channel = egr_free ? egr_channel : (!pend_empty ? pend_ch : drop_ch);

endmodule

/* pmem_egress.sv */
`timescale 1ns/1ps

module pmem_egress (
  input  logic                                                    clock,
  input  logic                                                    arst_n,
  input  logic [pmem_pkg::NUM_PORTS-1:0]                          job_valid,
  input  pmem_pkg::channel_t [pmem_pkg::NUM_PORTS-1:0]            job_channel,
  output logic [pmem_pkg::NUM_PORTS-1:0]                          job_pop,
  output pmem_pkg::channel_t                                      rd_channel,
  output pmem_pkg::word_idx_t                                     rd_word,
  input  logic [pmem_pkg::NUM_PORTS-1:0][pmem_pkg::DATA_W-1:0]    rd_data,
  input  pmem_pkg::len_t [pmem_pkg::NUM_PORTS-1:0]                rd_len,
  output logic [pmem_pkg::NUM_PORTS-1:0][pmem_pkg::DATA_W-1:0]    transmitout_data,
  output logic [pmem_pkg::NUM_PORTS-1:0]                          transmitout_valid,
  output logic [pmem_pkg::NUM_PORTS-1:0]                          transmitout_sop,
  output logic [pmem_pkg::NUM_PORTS-1:0]                          transmitout_eop,
  input  logic [pmem_pkg::NUM_PORTS-1:0]                          transmitout_ready,
  output logic                                                    egr_free,
  output pmem_pkg::channel_t                                      egr_channel
);

  import pmem_pkg::*;

  typedef struct packed {
    logic              sop;
    logic              eop;
    logic [DATA_W-1:0] data;
  } beat_t;

  logic busy;
  port_t cur_dest;
  channel_t cur_ch;
  port_t last_port;
  logic pick_valid;
  port_t pick_port;

  len_t rd_cnt;
  logic rd_first;
  logic rd_vld_q;
  word_idx_t rd_idx_q;
  len_t cur_len;
  beat_t ret_beat;
  logic issue;

  beat_t skid [2];
  logic [1:0] sk_cnt;
  logic sk_push;
  logic sk_pop;

  logic out_valid;
  beat_t out_beat;
  logic out_take;
  logic out_free;

  // Next non-empty queue after the last port served
  always_comb begin : rr_pick
    port_t cand;
    pick_valid = 1'b0;
    pick_port = last_port;
    for (int k = 1; k <= NUM_PORTS; k++) begin
      cand = port_t'(last_port + k);
      if (!pick_valid && job_valid[cand]) begin
        pick_valid = 1'b1;
        pick_port = cand;
      end
    end
  end

  assign job_pop = (!busy && pick_valid) ? (NUM_PORTS'(1) << pick_port) : '0;

  assign rd_channel = cur_ch;
  assign rd_word = word_idx_t'(rd_cnt);

  // Length is valid from the cycle after the first read
  assign cur_len = rd_len[cur_ch.port];
  assign ret_beat.data = rd_data[cur_ch.port];
  assign ret_beat.sop = (rd_idx_q == '0);
  assign ret_beat.eop = (len_t'(rd_idx_q) + len_t'(1) == cur_len);

  assign out_take = out_valid && transmitout_ready[cur_dest];
  assign out_free = !out_valid || out_take;
  assign issue = busy && out_free && (rd_first || rd_cnt < cur_len);

  // Returned word bypasses the skid when it is empty and the output can load
  assign sk_pop = out_free && (sk_cnt != '0);
  assign sk_push = rd_vld_q && !(out_free && sk_cnt == '0);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      cur_dest <= '0;
      cur_ch <= '0;
      last_port <= port_t'(NUM_PORTS - 1);
      rd_cnt <= '0;
      rd_first <= 1'b0;
      rd_vld_q <= 1'b0;
      rd_idx_q <= '0;
      sk_cnt <= '0;
      out_valid <= 1'b0;
      egr_free <= 1'b0;
    end else begin
      if (!busy && pick_valid) begin
        busy <= 1'b1;
        cur_dest <= pick_port;
        cur_ch <= job_channel[pick_port];
        rd_cnt <= '0;
        rd_first <= 1'b1;
      end else if (out_take && out_beat.eop) begin
        busy <= 1'b0;
        last_port <= cur_dest;
      end
      if (issue) begin
        rd_cnt <= rd_cnt + len_t'(1);
        rd_first <= 1'b0;
      end
      rd_vld_q <= issue;
      rd_idx_q <= rd_word;
      sk_cnt <= sk_cnt + 2'(sk_push) - 2'(sk_pop);
      if (out_free) begin
        out_valid <= (sk_cnt != '0) || rd_vld_q;
      end
      egr_free <= out_take && out_beat.eop;
    end
  end

  always_ff @(posedge clock) begin
    if (sk_pop) begin
      skid[0] <= skid[1];
    end
    if (sk_push) begin
      skid[1'(sk_cnt - 2'(sk_pop))] <= ret_beat;
    end
    if (out_free) begin
      out_beat <= (sk_cnt != '0) ? skid[0] : ret_beat;
    end
    if (out_take && out_beat.eop) begin
      egr_channel <= cur_ch;
    end
  end

  always_comb begin
    for (int d = 0; d < NUM_PORTS; d++) begin
      transmitout_data[d] = out_beat.data;
      transmitout_sop[d] = out_beat.sop;
      transmitout_eop[d] = out_beat.eop;
      transmitout_valid[d] = out_valid && (cur_dest == port_t'(d));
    end
  end

endmodule

/* pmem_group.sv */
`timescale 1ns/1ps

module pmem_group (
  input  logic                                                  clock,
  input  logic                                                  arst_n,

  input  logic [pmem_pkg::NUM_PORTS-1:0][pmem_pkg::DATA_W-1:0]  packetin_data,
  input  logic [pmem_pkg::NUM_PORTS-1:0]                        packetin_valid,
  input  logic [pmem_pkg::NUM_PORTS-1:0]                        packetin_sop,
  input  logic [pmem_pkg::NUM_PORTS-1:0]                        packetin_eop,
  output logic [pmem_pkg::NUM_PORTS-1:0]                        packetin_ready,

  output logic [pmem_pkg::NUM_PORTS-1:0][pmem_pkg::DATA_W-1:0]  packetout_data,
  output logic [pmem_pkg::NUM_PORTS-1:0]                        packetout_valid,
  output logic [pmem_pkg::NUM_PORTS-1:0]                        packetout_sop,
  output logic [pmem_pkg::NUM_PORTS-1:0]                        packetout_eop,
  input  logic [pmem_pkg::NUM_PORTS-1:0]                        packetout_ready,
  output pmem_pkg::channel_t [pmem_pkg::NUM_PORTS-1:0]          packetout_channel,

  output logic [pmem_pkg::NUM_PORTS-1:0][pmem_pkg::DATA_W-1:0]  transmitout_data,
  output logic [pmem_pkg::NUM_PORTS-1:0]                        transmitout_valid,
  output logic [pmem_pkg::NUM_PORTS-1:0]                        transmitout_sop,
  output logic [pmem_pkg::NUM_PORTS-1:0]                        transmitout_eop,
  input  logic [pmem_pkg::NUM_PORTS-1:0]                        transmitout_ready,

  input  pmem_pkg::tag_t                                        tagin_data,
  input  logic                                                  tagin_valid,
  output logic                                                  tagin_ready
);

  import pmem_pkg::*;

  logic free_valid;
  channel_t free_channel;
  channel_t rd_channel;
  word_idx_t rd_word;
  logic [NUM_PORTS-1:0][DATA_W-1:0] rd_data;
  len_t [NUM_PORTS-1:0] rd_len;

  logic [NUM_PORTS-1:0] job_valid;
  channel_t [NUM_PORTS-1:0] job_channel;
  logic [NUM_PORTS-1:0] job_pop;
  logic egr_free;
  channel_t egr_channel;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_ingress
    pmem_ingress #(
      .PORT (port_t'(p))
    ) u_ingress (
      .clock             (clock),
      .arst_n            (arst_n),
      .packetin_data     (packetin_data[p]),
      .packetin_valid    (packetin_valid[p]),
      .packetin_sop      (packetin_sop[p]),
      .packetin_eop      (packetin_eop[p]),
      .packetin_ready    (packetin_ready[p]),
      .packetout_data    (packetout_data[p]),
      .packetout_valid   (packetout_valid[p]),
      .packetout_sop     (packetout_sop[p]),
      .packetout_eop     (packetout_eop[p]),
      .packetout_ready   (packetout_ready[p]),
      .packetout_channel (packetout_channel[p]),
      .free_valid        (free_valid),
      .free_channel      (free_channel),
      .rd_channel        (rd_channel),
      .rd_word           (rd_word),
      .rd_data           (rd_data[p]),
      .rd_len            (rd_len[p])
    );
  end

  pmem_dispatch u_dispatch (
    .clock        (clock),
    .arst_n       (arst_n),
    .tagin_data   (tagin_data),
    .tagin_valid  (tagin_valid),
    .tagin_ready  (tagin_ready),
    .job_valid    (job_valid),
    .job_channel  (job_channel),
    .job_pop      (job_pop),
    .egr_free     (egr_free),
    .egr_channel  (egr_channel),
    .free_valid   (free_valid),
    .free_channel (free_channel)
  );

  pmem_egress u_egress (
    .clock             (clock),
    .arst_n            (arst_n),
    .job_valid         (job_valid),
    .job_channel       (job_channel),
    .job_pop           (job_pop),
    .rd_channel        (rd_channel),
    .rd_word           (rd_word),
    .rd_data           (rd_data),
    .rd_len            (rd_len),
    .transmitout_data  (transmitout_data),
    .transmitout_valid (transmitout_valid),
    .transmitout_sop   (transmitout_sop),
    .transmitout_eop   (transmitout_eop),
    .transmitout_ready (transmitout_ready),
    .egr_free          (egr_free),
    .egr_channel       (egr_channel)
  );

endmodule

/* tb_pmem_group.sv */
`timescale 1ns/1ps

module tb_pmem_group;

  import pmem_pkg::*;

  localparam int TIMEOUT = 2000;
  localparam int NUM_TESTS = 10;

  typedef struct {
    string       name;
    int          port;
    int          len;
    int          dest;
    bit          drop;
    bit          hold;
    bit          fill;
    bit          bp;
    logic [31:0] seed;
  } entry_t;

  // hold keeps the tag back until the next row without it
  // fill takes all sixteen slots of the port first
  entry_t tests [NUM_TESTS] = '{
    '{"pass_p0",  0, 3, 1, 0, 0, 0, 0, 32'h11},
    '{"pass_p3",  3, 8, 0, 0, 0, 0, 0, 32'h22},
    '{"alloc_s0", 1, 2, 2, 0, 1, 0, 0, 32'h33},
    '{"alloc_s1", 1, 4, 0, 0, 1, 0, 0, 32'h44},
    '{"alloc_s2", 1, 1, 3, 0, 0, 0, 0, 32'h55},
    '{"drop_p2",  2, 5, 0, 1, 0, 0, 0, 32'h66},
    '{"reuse_p2", 2, 2, 1, 0, 0, 0, 0, 32'h77},
    '{"capacity", 0, 2, 2, 0, 0, 1, 0, 32'h88},
    '{"bp_p1",    1, 8, 3, 0, 0, 0, 1, 32'h99},
    '{"bp_p2",    2, 6, 2, 0, 0, 0, 1, 32'haa}
  };

  logic clock = 1'b0;
  logic arst_n;
  logic [NUM_PORTS-1:0][DATA_W-1:0] packetin_data;
  logic [NUM_PORTS-1:0] packetin_valid;
  logic [NUM_PORTS-1:0] packetin_sop;
  logic [NUM_PORTS-1:0] packetin_eop;
  logic [NUM_PORTS-1:0] packetin_ready;
  logic [NUM_PORTS-1:0][DATA_W-1:0] packetout_data;
  logic [NUM_PORTS-1:0] packetout_valid;
  logic [NUM_PORTS-1:0] packetout_sop;
  logic [NUM_PORTS-1:0] packetout_eop;
  logic [NUM_PORTS-1:0] packetout_ready;
  channel_t [NUM_PORTS-1:0] packetout_channel;
  logic [NUM_PORTS-1:0][DATA_W-1:0] transmitout_data;
  logic [NUM_PORTS-1:0] transmitout_valid;
  logic [NUM_PORTS-1:0] transmitout_sop;
  logic [NUM_PORTS-1:0] transmitout_eop;
  logic [NUM_PORTS-1:0] transmitout_ready;
  tag_t tagin_data;
  logic tagin_valid;
  logic tagin_ready;

  tag_t tag_q [$];
  tag_t held [$];
  // Beats are {sop, eop, data}
  logic [DATA_W+1:0] exp_q [NUM_PORTS][$];
  logic [DATA_W+1:0] rx_q [NUM_PORTS][$];
  logic [DATA_W-1:0] pkt_words [NUM_PORTS][SLOTS][MAX_WORDS];
  int pkt_len [NUM_PORTS][SLOTS];
  logic [SLOTS-1:0] used [NUM_PORTS];
  logic bp_on = 1'b0;
  logic [63:0] bp_state;
  int errors;
  int failed;

  pmem_group DUT (
    .clock             (clock),
    .arst_n            (arst_n),
    .packetin_data     (packetin_data),
    .packetin_valid    (packetin_valid),
    .packetin_sop      (packetin_sop),
    .packetin_eop      (packetin_eop),
    .packetin_ready    (packetin_ready),
    .packetout_data    (packetout_data),
    .packetout_valid   (packetout_valid),
    .packetout_sop     (packetout_sop),
    .packetout_eop     (packetout_eop),
    .packetout_ready   (packetout_ready),
    .packetout_channel (packetout_channel),
    .transmitout_data  (transmitout_data),
    .transmitout_valid (transmitout_valid),
    .transmitout_sop   (transmitout_sop),
    .transmitout_eop   (transmitout_eop),
    .transmitout_ready (transmitout_ready),
    .tagin_data        (tagin_data),
    .tagin_valid       (tagin_valid),
    .tagin_ready       (tagin_ready)
  );

  always #10 clock = ~clock;

  function automatic logic [63:0] xorshift(input logic [63:0] x);
    logic [63:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 7);
    y = y ^ (y << 17);
    return y;
  endfunction

  // Start state for the data words of one packet
  function automatic logic [63:0] seed_state(input logic [31:0] seed);
    return 64'd40105 ^ {seed, 32'h0};
  endfunction

  function automatic int lowest_free(input int p);
    for (int s = 0; s < SLOTS; s++) begin
      if (!used[p][s]) begin
        return s;
      end
    end
    return 0;
  endfunction

  function automatic tag_t make_tag(input channel_t ch, input int dest, input bit drop);
    tag_t t;
    t.rsvd = 1'b0;
    t.drop = drop;
    t.dest = port_t'(dest);
    t.channel = ch;
    return t;
  endfunction

  function automatic bit rx_done();
    for (int d = 0; d < NUM_PORTS; d++) begin
      if (rx_q[d].size() < exp_q[d].size()) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic timeout_fail(input string what);
    $display("timeout: no %s within %0d cycles", what, TIMEOUT);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_channel(input string name, input channel_t exp, input channel_t act);
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic send_packet(input string name, input int p, input int len,
                             input logic [31:0] seed, output channel_t ch);
    logic [63:0] st;
    channel_t exp_ch;
    int wait_cnt;
    st = seed_state(seed);
    exp_ch.port = port_t'(p);
    exp_ch.slot = slot_t'(lowest_free(p));
    ch = exp_ch;
    for (int i = 0; i < len; i++) begin
      st = xorshift(st);
      packetin_data[p] = st;
      packetin_sop[p] = (i == 0);
      packetin_eop[p] = (i == len - 1);
      packetin_valid[p] = 1'b1;
      wait_cnt = 0;
      do begin
        @(posedge clock);
        wait_cnt++;
        if (wait_cnt > TIMEOUT) begin
          timeout_fail("packetin_ready");
        end
      end while (!packetin_ready[p]);
      check_flag({name, " out valid"}, 1'b1, packetout_valid[p]);
      check_word({name, " out data"}, st, packetout_data[p]);
      check_flag({name, " out sop"}, (i == 0), packetout_sop[p]);
      check_flag({name, " out eop"}, (i == len - 1), packetout_eop[p]);
      if (i == 0) begin
        ch = packetout_channel[p];
        check_channel({name, " slot"}, exp_ch, ch);
      end else begin
        // Same channel on every word
        check_channel({name, " channel"}, ch, packetout_channel[p]);
      end
      pkt_words[p][ch.slot][i] = st;
      #1;
    end
    packetin_valid[p] = 1'b0;
    packetin_sop[p] = 1'b0;
    packetin_eop[p] = 1'b0;
    pkt_len[p][ch.slot] = len;
    used[p][ch.slot] = 1'b1;
  endtask

  task automatic issue_tag(input tag_t t);
    int p;
    int s;
    p = int'(t.channel.port);
    s = int'(t.channel.slot);
    tag_q.push_back(t);
    if (!t.drop) begin
      for (int i = 0; i < pkt_len[p][s]; i++) begin
        exp_q[t.dest].push_back({i == 0, i == pkt_len[p][s] - 1, pkt_words[p][s][i]});
      end
    end
    used[p][s] = 1'b0;
  endtask

  task automatic wait_tags_sent();
    int wait_cnt;
    wait_cnt = 0;
    while (tag_q.size() != 0) begin
      @(posedge clock);
      #1;
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        timeout_fail("tag handshake");
      end
    end
  endtask

  task automatic drain_and_compare(input string name);
    int wait_cnt;
    logic [DATA_W+1:0] e;
    logic [DATA_W+1:0] a;
    wait_cnt = 0;
    while (!rx_done()) begin
      @(posedge clock);
      #1;
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        timeout_fail("transmit words");
      end
    end
    // Slot is allocatable again two cycles after the last handshake
    repeat (2) @(posedge clock);
    #1;
    for (int d = 0; d < NUM_PORTS; d++) begin
      while (exp_q[d].size() != 0) begin
        e = exp_q[d].pop_front();
        a = rx_q[d].pop_front();
        check_word({name, " tx data"}, e[DATA_W-1:0], a[DATA_W-1:0]);
        check_flag({name, " tx sop"}, e[DATA_W+1], a[DATA_W+1]);
        check_flag({name, " tx eop"}, e[DATA_W], a[DATA_W]);
      end
      if (rx_q[d].size() != 0) begin
        $display("%s: %0d unexpected words on transmit port %0d", name, rx_q[d].size(), d);
        errors++;
        rx_q[d].delete();
      end
    end
  endtask

  task automatic run_entry(input entry_t e);
    channel_t ch;
    int err_before;
    err_before = errors;
    bp_on = e.bp;
    if (e.fill) begin
      for (int i = 0; i < SLOTS; i++) begin
        send_packet(e.name, e.port, 1 + i % MAX_WORDS, e.seed + 32'(i), ch);
        held.push_back(make_tag(ch, e.dest, (i == 0) ? e.drop : 1'b1));
      end
      // Seventeenth packet offered while the bank is full
      packetin_data[e.port] = xorshift(seed_state(e.seed));
      packetin_sop[e.port] = 1'b1;
      packetin_eop[e.port] = (e.len == 1);
      packetin_valid[e.port] = 1'b1;
      repeat (4) begin
        @(posedge clock);
        check_flag({e.name, " ready while full"}, 1'b0, packetin_ready[e.port]);
        #1;
      end
      issue_tag(held.pop_front());
      send_packet(e.name, e.port, e.len, e.seed, ch);
      held.push_back(make_tag(ch, e.dest, 1'b1));
    end else begin
      send_packet(e.name, e.port, e.len, e.seed, ch);
      held.push_back(make_tag(ch, e.dest, e.drop));
    end
    if (!e.hold) begin
      while (held.size() != 0) begin
        issue_tag(held.pop_front());
      end
      wait_tags_sent();
      drain_and_compare(e.name);
    end
    if (errors == err_before) begin
      $display("ok    %s", e.name);
    end else begin
      $display("fail  %s, %0d mismatches", e.name, errors - err_before);
      failed++;
    end
  endtask

  // Matcher model issuing tags in the order they were queued
  initial begin : matcher
    int stall;
    stall = 0;
    tagin_valid = 1'b0;
    tagin_data = '0;
    forever begin
      @(posedge clock);
      if (tagin_valid && tagin_ready) begin
        void'(tag_q.pop_front());
        stall = 0;
      end else if (tagin_valid) begin
        stall++;
        if (stall > TIMEOUT) begin
          timeout_fail("tagin_ready");
        end
      end
      #1;
      tagin_valid = (tag_q.size() != 0);
      tagin_data = (tag_q.size() != 0) ? tag_q[0] : '0;
    end
  end

  initial begin : tx_ready_gen
    bp_state = 64'd40105;
    transmitout_ready = '1;
    forever begin
      @(posedge clock);
      #1;
      bp_state = xorshift(bp_state);
      transmitout_ready = bp_on ? bp_state[NUM_PORTS-1:0] : '1;
    end
  end

  always @(posedge clock) begin
    for (int d = 0; d < NUM_PORTS; d++) begin
      if (arst_n && transmitout_valid[d] && transmitout_ready[d]) begin
        rx_q[d].push_back({transmitout_sop[d], transmitout_eop[d], transmitout_data[d]});
      end
    end
  end

  initial begin : main
    errors = 0;
    failed = 0;
    arst_n = 1'b0;
    packetin_data = '0;
    packetin_valid = '0;
    packetin_sop = '0;
    packetin_eop = '0;
    packetout_ready = '1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      used[p] = '0;
    end
    repeat (4) @(posedge clock);
    #1;
    arst_n = 1'b1;
    @(posedge clock);
    #1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_entry(tests[t]);
    end
    // Late words from a dropped or misrouted packet
    bp_on = 1'b0;
    repeat (20) @(posedge clock);
    for (int d = 0; d < NUM_PORTS; d++) begin
      if (rx_q[d].size() != 0) begin
        $display("%0d stray words on transmit port %0d", rx_q[d].size(), d);
        errors++;
      end
    end
    $display("%0d tests run, %0d failed, %0d mismatches", NUM_TESTS, failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* sources.f */
pmem_pkg.sv
pmem_fifo.sv
pmem_ingress.sv
pmem_dispatch.sv
pmem_egress.sv
pmem_group.sv
tb_pmem_group.sv

/* Makefile */
# Verilator simulation of the packet memory group

SIM = obj_dir/sim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

$(SIM): sources.f $(wildcard *.sv)
	verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_pmem_group -o sim

test: $(SIM)
	rm -f sim.log
	./$(SIM) | tee sim.log
	@grep -q -F '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
